/* sources.f */
design/tag_req_pkg.sv
design/tag_table_mem.sv
design/tag_req_arbiter.sv
design/tag_lookup_engine.sv
design/tag_req_top.sv
verification/tb_clock_gen.sv
verification/tag_req_tb.sv

/* Bender.yml */
package:
  name: tag_req

sources:
  - design/tag_req_pkg.sv
  - design/tag_table_mem.sv
  - design/tag_req_arbiter.sv
  - design/tag_lookup_engine.sv
  - design/tag_req_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/tag_req_tb.sv

/* verification/tag_req_tb.sv */
/*
 * Tag lookup subsystem testbench.
 * Random table programming and PU lookup traffic, checked against
 * a model of the tables, the round-robin grant and the lookups.
 */
module tag_req_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import tag_req_pkg::*;

	localparam int NUM_PU       = 4;
	localparam int PID_W        = 2;
	localparam int N_RAND_WR    = 40;
	localparam int N_T0         = 6;
	localparam int N_T1         = 6;
	localparam int N_MISS       = 6;
	localparam int N_BURST      = 10;
	localparam int BURST_CYCLES = 6;
	localparam int REG_OPS      = N_RAND_WR + 64 + N_T0 + 2 * N_T1 + 2 * N_MISS;
	localparam int LOOKUPS      = N_T0 + N_T1 + N_MISS + NUM_PU +
		N_BURST * BURST_CYCLES * NUM_PU + 1;
	localparam int LIMIT        = 20 * (REG_OPS + LOOKUPS);

	logic clk, rst_n;
	logic [NUM_PU-1:0] io_req, io_wr, io_ack;
	logic [IO_ADDR_W-1:0] io_addr [NUM_PU];
	logic [REG_W-1:0] io_wdata [NUM_PU];
	logic [7:0] reg_addr;
	logic [REG_W-1:0] reg_din, hash_mem_rdata, value_mem_rdata;
	logic reg_rd, reg_wr, reg_sel_hash, reg_sel_value;
	logic hash_mem_ack, value_mem_ack;
	logic lookup_valid, status_valid;
	logic [RESULT_W-1:0] lookup_result;
	logic [2:0] lookup_result_num;
	logic [PID_W-1:0] lookup_result_pid, status_pid;
	logic [3:0] status;

	// Model state
	logic [31:0] ht_m [2][16];
	logic [15:0] val_m [32];
	logic [NUM_PU-1:0] mp;		// Mirror of the DUT pending flags
	logic [NUM_PU-1:0] macc;	// Accepted in the last cycle
	logic [NUM_PU-1:0] waiting;	// Issued and not yet acked
	logic [15:0] tag_m [NUM_PU];
	logic [15:0] req_tag [NUM_PU];
	logic [15:0] known_tags [$];
	int exp_pid_q [$];
	logic [15:0] exp_tag_q [$];
	int last_gnt;
	int res_idx;
	int cycles;
	logic [31:0] rng_state;

	tb_clock_gen #(.PERIOD_NS(8), .RST_CYCLES(5)) clk_gen_inst (.clk(clk), .rst_n(rst_n));

	tag_req_top #(.NUM_PU(NUM_PU)) tag_req_top_inst (
		.clk(clk), .rst_n(rst_n),
		.io_req(io_req), .io_wr(io_wr), .io_addr(io_addr), .io_wdata(io_wdata),
		.io_ack(io_ack),
		.reg_addr(reg_addr), .reg_din(reg_din), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_sel_hash(reg_sel_hash), .reg_sel_value(reg_sel_value),
		.hash_mem_ack(hash_mem_ack), .hash_mem_rdata(hash_mem_rdata),
		.value_mem_ack(value_mem_ack), .value_mem_rdata(value_mem_rdata),
		.lookup_valid(lookup_valid), .lookup_result(lookup_result),
		.lookup_result_num(lookup_result_num), .lookup_result_pid(lookup_result_pid),
		.status_valid(status_valid), .status(status), .status_pid(status_pid)
	);

	//--------------------------------------------------
	// Helpers
	//--------------------------------------------------
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [3:0] bkt0(input logic [15:0] tag);
		return tag[3:0] ^ tag[11:8];
	endfunction

	function automatic logic [3:0] bkt1(input logic [15:0] tag);
		return tag[7:4] ^ tag[15:12];
	endfunction

	function automatic logic [31:0] make_bucket(input logic valid, input logic [2:0] cnt,
			input logic [4:0] base, input logic [15:0] tag);
		return {valid, 7'd0, cnt, base, tag};
	endfunction

	// Matching bucket word or zero on a miss
	function automatic logic [31:0] expected_bucket(input logic [15:0] tag);
		logic [31:0] w0, w1;
		w0 = ht_m[0][bkt0(tag)];
		w1 = ht_m[1][bkt1(tag)];
		if (w0[31] && w0[15:0] == tag && w0[23:21] != 3'd0)
			return w0;
		if (w1[31] && w1[15:0] == tag && w1[23:21] != 3'd0)
			return w1;
		return '0;
	endfunction

	function automatic int rr_pick(input logic [NUM_PU-1:0] pend, input int last);
		int c;
		for (int k = 1; k <= NUM_PU; k++) begin
			c = (last + k) % NUM_PU;
			if (pend[c])
				return c;
		end
		return -1;
	endfunction

	task automatic report_error(input string msg);
		$display("%0t: %s", $time, msg);
		$display("Test FAILED");
		$fatal(1, "Simulation stopped after an error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1, "Simulation stopped after an error");
		end
	endtask

	//--------------------------------------------------
	// Register port
	//--------------------------------------------------
	task automatic reg_access(input bit hash, input bit wr, input logic [7:0] addr,
			input logic [31:0] data);
		@(posedge clk);
		reg_addr      <= addr;
		reg_din       <= data;
		reg_wr        <= wr;
		reg_rd        <= !wr;
		reg_sel_hash  <= hash;
		reg_sel_value <= !hash;
		@(negedge clk);
		check_value("hash_mem_ack", hash_mem_ack, 0);	// Not before next cycle
		check_value("value_mem_ack", value_mem_ack, 0);
		@(posedge clk);
		reg_wr        <= 1'b0;
		reg_rd        <= 1'b0;
		reg_sel_hash  <= 1'b0;
		reg_sel_value <= 1'b0;
		@(negedge clk);
		check_value("hash_mem_ack", hash_mem_ack, hash);
		check_value("value_mem_ack", value_mem_ack, !hash);
		if (wr && hash)
			ht_m[addr[4]][addr[3:0]] = data;
		else if (wr)
			val_m[addr[4:0]] = data[15:0];
		else if (hash)
			check_value("hash_mem_rdata", hash_mem_rdata, ht_m[addr[4]][addr[3:0]]);
		else
			check_value("value_mem_rdata", value_mem_rdata, {16'd0, val_m[addr[4:0]]});
	endtask

	//--------------------------------------------------
	// PU requests
	//--------------------------------------------------
	task automatic send_requests(input logic [NUM_PU-1:0] mask);
		@(posedge clk);
		for (int p = 0; p < NUM_PU; p++) begin
			io_req[p]   <= mask[p];
			io_wr[p]    <= 1'b1;
			io_addr[p]  <= TAG_LOOKUP_ADDR;
			io_wdata[p] <= (next_rand() << 16) | 32'(req_tag[p]);
		end
		waiting |= mask;
		@(posedge clk);
		io_req <= '0;
	endtask

	task automatic wait_done();
		do
			@(negedge clk);
		while (waiting != '0 || mp != '0 || exp_pid_q.size() != 0);
		repeat (2) @(negedge clk);
	endtask

	function automatic logic [15:0] pick_tag();
		logic [31:0] r;
		r = next_rand();
		if (r[31] && known_tags.size() != 0)
			return known_tags[r[7:0] % known_tags.size()];
		return r[15:0];
	endfunction

	//--------------------------------------------------
	// Grant, result and status monitor
	//--------------------------------------------------
	always @(negedge clk) begin : monitor
		logic [31:0] bw;
		if (!rst_n) begin
			mp       = '0;
			macc     = '0;
			last_gnt = NUM_PU - 1;
			res_idx  = 0;
		end else begin
			if (!$onehot0(io_ack))
				report_error($sformatf("io_ack pulsed for several PUs: %b", io_ack));
			for (int p = 0; p < NUM_PU; p++) begin
				if (io_ack[p]) begin
					if (!mp[p])
						report_error($sformatf("io_ack for PU %0d with nothing pending", p));
					check_value("grant pid", p, rr_pick(mp, last_gnt));
					last_gnt = p;
					exp_pid_q.push_back(p);
					exp_tag_q.push_back(tag_m[p]);
					waiting[p] = 1'b0;
				end
			end
			mp = (mp & ~io_ack) | macc;
			for (int p = 0; p < NUM_PU; p++) begin
				macc[p] = io_req[p] & io_wr[p] & (io_addr[p] == 12'h0A0) & ~mp[p];
				if (macc[p])
					tag_m[p] = io_wdata[p][15:0];
			end
			if (lookup_valid) begin
				if (exp_pid_q.size() == 0)
					report_error("lookup_valid with no lookup in progress");
				bw = expected_bucket(exp_tag_q[0]);
				if (res_idx >= int'(bw[23:21]))
					report_error("More lookup results than the bucket count");
				check_value("lookup_result_pid", lookup_result_pid, exp_pid_q[0]);
				check_value("lookup_result_num", lookup_result_num, res_idx);
				check_value("lookup_result", lookup_result,
					val_m[(bw[20:16] + res_idx) % 32]);
				res_idx++;
			end
			if (status_valid) begin
				if (exp_pid_q.size() == 0)
					report_error("status_valid with no lookup in progress");
				bw = expected_bucket(exp_tag_q[0]);
				check_value("status_pid", status_pid, exp_pid_q[0]);
				check_value("status", status, bw[31] ? 4'd1 : 4'd2);
				check_value("result count", res_idx, bw[31] ? bw[23:21] : 0);
				void'(exp_pid_q.pop_front());
				void'(exp_tag_q.pop_front());
				res_idx = 0;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("Test FAILED");
			$fatal(1, "Simulation stopped on timeout");
		end
	end

	//--------------------------------------------------
	// Stimulus
	//--------------------------------------------------
	initial begin
		logic [31:0] r;
		logic [15:0] tag;
		int pid;
		rng_state = 32'h4de5_8b3f;
		cycles    = 0;
		waiting   = '0;
		io_req    = '0;
		io_wr     = '0;
		reg_addr  = '0;
		reg_din   = '0;
		{reg_rd, reg_wr, reg_sel_hash, reg_sel_value} = '0;
		for (int p = 0; p < NUM_PU; p++) begin
			io_addr[p]  = '0;
			io_wdata[p] = '0;
			req_tag[p]  = '0;
		end
		for (int i = 0; i < 32; i++) begin
			val_m[i] = '0;
			ht_m[i / 16][i % 16] = '0;	// Tables clear after reset
		end
		wait (rst_n === 1'b1);

		// Register access
		for (int i = 0; i < N_RAND_WR; i++) begin
			r = next_rand();
			reg_access(r[0], 1'b1, {3'd0, r[5:1]}, next_rand());
		end
		for (int i = 0; i < 32; i++)
			reg_access(1'b1, 1'b0, 8'(i), '0);
		for (int i = 0; i < 32; i++)
			reg_access(1'b0, 1'b0, 8'(i), '0);

		// Table 0 hits
		for (int i = 0; i < N_T0; i++) begin
			r   = next_rand();
			tag = r[15:0];
			pid = r[17:16];
			reg_access(1'b1, 1'b1, {4'd0, bkt0(tag)},
				make_bucket(1'b1, 3'(1 + r[31:20] % 7), r[24:20], tag));
			known_tags.push_back(tag);
			req_tag[pid] = tag;
			send_requests(NUM_PU'(1) << pid);
			wait_done();
		end

		// Table 1 hits
		for (int i = 0; i < N_T1; i++) begin
			r   = next_rand();
			tag = r[15:0];
			pid = r[17:16];
			reg_access(1'b1, 1'b1, {4'd0, bkt0(tag)}, '0);
			reg_access(1'b1, 1'b1, {4'd1, bkt1(tag)},
				make_bucket(1'b1, 3'(1 + r[31:20] % 7), r[24:20], tag));
			known_tags.push_back(tag);
			req_tag[pid] = tag;
			send_requests(NUM_PU'(1) << pid);
			wait_done();
		end

		// Misses by other tags or a zero count
		for (int i = 0; i < N_MISS; i++) begin
			r   = next_rand();
			tag = r[15:0];
			pid = r[17:16];
			if (i % 2 == 0) begin
				reg_access(1'b1, 1'b1, {4'd0, bkt0(tag)},
					make_bucket(1'b1, 3'd3, r[24:20], tag ^ 16'h8000));
				reg_access(1'b1, 1'b1, {4'd1, bkt1(tag)},
					make_bucket(1'b1, 3'd2, r[28:24], tag ^ 16'h0001));
			end else begin
				reg_access(1'b1, 1'b1, {4'd0, bkt0(tag)},
					make_bucket(1'b1, 3'd0, r[24:20], tag));
				reg_access(1'b1, 1'b1, {4'd1, bkt1(tag)}, '0);
			end
			req_tag[pid] = tag;
			send_requests(NUM_PU'(1) << pid);
			wait_done();
		end

		// Concurrent requests
		for (int p = 0; p < NUM_PU; p++)
			req_tag[p] = pick_tag();
		send_requests('1);
		wait_done();
		for (int b = 0; b < N_BURST; b++) begin
			for (int c = 0; c < BURST_CYCLES; c++) begin
				for (int p = 0; p < NUM_PU; p++)
					req_tag[p] = pick_tag();
				r = next_rand();
				send_requests(r[NUM_PU-1:0] & ~waiting);
			end
			wait_done();
		end

		// One real request, its repeat, a stray write and a read
		@(posedge clk);
		io_req      <= 4'b1110;
		io_wr       <= 4'b0110;
		io_addr[1]  <= TAG_LOOKUP_ADDR;
		io_wdata[1] <= {16'd0, pick_tag()};
		io_addr[2]  <= 12'h0A4;
		io_addr[3]  <= TAG_LOOKUP_ADDR;
		waiting[1]  = 1'b1;
		@(posedge clk);
		io_req      <= 4'b0010;	// Repeat while pending
		io_wdata[1] <= {16'd0, pick_tag()};
		@(posedge clk);
		io_req      <= '0;
		wait_done();

		$display("Test OK");
		$finish;
	end

endmodule

/* verification/tb_clock_gen.sv */
/*
 * Testbench clock and reset generator.
 * Free running clock, reset held low for a number of cycles.
 */
module tb_clock_gen #(
	parameter int PERIOD_NS  = 8,
	parameter int RST_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial clk = 1'b0;
	always #(PERIOD_NS / 2.0) clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* design/tag_req_top.sv */
/*
 * Tag lookup subsystem top level.
 * PU lookup requests go through the round-robin arbiter to the
 * lookup engine, which reads the register-programmed tables.
 */
module tag_req_top #(
	parameter int NUM_PU = 4,
	localparam int PID_W = (NUM_PU > 1) ? $clog2(NUM_PU) : 1
) (
	input  logic clk,
	input  logic rst_n,

	input  logic [NUM_PU-1:0] io_req,
	input  logic [NUM_PU-1:0] io_wr,
	input  logic [tag_req_pkg::IO_ADDR_W-1:0] io_addr [NUM_PU],
	input  logic [tag_req_pkg::REG_W-1:0] io_wdata [NUM_PU],
	output logic [NUM_PU-1:0] io_ack,

	input  logic [7:0] reg_addr,
	input  logic [tag_req_pkg::REG_W-1:0] reg_din,
	input  logic reg_rd,
	input  logic reg_wr,
	input  logic reg_sel_hash,
	input  logic reg_sel_value,
	output logic hash_mem_ack,
	output logic [tag_req_pkg::REG_W-1:0] hash_mem_rdata,
	output logic value_mem_ack,
	output logic [tag_req_pkg::REG_W-1:0] value_mem_rdata,

	output logic lookup_valid,
	output logic [tag_req_pkg::RESULT_W-1:0] lookup_result,
	output logic [tag_req_pkg::CNT_W-1:0] lookup_result_num,
	output logic [PID_W-1:0] lookup_result_pid,
	output logic status_valid,
	output logic [tag_req_pkg::STATUS_W-1:0] status,
	output logic [PID_W-1:0] status_pid
);
	import tag_req_pkg::*;

	logic engine_idle;
	logic key_valid;
	logic [TAG_W-1:0] key_tag;
	logic [PID_W-1:0] key_pid;

	logic ht0_rd, ht1_rd, val_rd;
	logic [HT_DEPTH_W-1:0] ht0_raddr, ht1_raddr;
	logic [VAL_DEPTH_W-1:0] val_raddr;
	logic ht0_ack, ht1_ack, val_ack;
	logic [REG_W-1:0] ht0_rdata, ht1_rdata;
	logic [RESULT_W-1:0] val_rdata;

	tag_req_arbiter #(.NUM_PU(NUM_PU)) tag_req_arbiter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.io_req(io_req),
		.io_wr(io_wr),
		.io_addr(io_addr),
		.io_wdata(io_wdata),
		.engine_idle(engine_idle),
		.io_ack(io_ack),
		.key_valid(key_valid),
		.key_tag(key_tag),
		.key_pid(key_pid)
	);

	tag_lookup_engine #(.NUM_PU(NUM_PU)) tag_lookup_engine_inst (
		.clk(clk),
		.rst_n(rst_n),
		.key_valid(key_valid),
		.key_tag(key_tag),
		.key_pid(key_pid),
		.ht0_ack(ht0_ack),
		.ht0_rdata(ht0_rdata),
		.ht1_ack(ht1_ack),
		.ht1_rdata(ht1_rdata),
		.val_ack(val_ack),
		.val_rdata(val_rdata),
		.engine_idle(engine_idle),
		.ht0_rd(ht0_rd),
		.ht0_raddr(ht0_raddr),
		.ht1_rd(ht1_rd),
		.ht1_raddr(ht1_raddr),
		.val_rd(val_rd),
		.val_raddr(val_raddr),
		.lookup_valid(lookup_valid),
		.lookup_result(lookup_result),
		.lookup_result_num(lookup_result_num),
		.lookup_result_pid(lookup_result_pid),
		.status_valid(status_valid),
		.status(status),
		.status_pid(status_pid)
	);

	tag_table_mem tag_table_mem_inst (
		.clk(clk),
		.rst_n(rst_n),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.reg_sel_hash(reg_sel_hash),
		.reg_sel_value(reg_sel_value),
		.ht0_rd(ht0_rd),
		.ht0_raddr(ht0_raddr),
		.ht1_rd(ht1_rd),
		.ht1_raddr(ht1_raddr),
		.val_rd(val_rd),
		.val_raddr(val_raddr),
		.hash_mem_ack(hash_mem_ack),
		.hash_mem_rdata(hash_mem_rdata),
		.value_mem_ack(value_mem_ack),
		.value_mem_rdata(value_mem_rdata),
		.ht0_ack(ht0_ack),
		.ht0_rdata(ht0_rdata),
		.ht1_ack(ht1_ack),
		.ht1_rdata(ht1_rdata),
		.val_ack(val_ack),
		.val_rdata(val_rdata)
	);

endmodule

/* design/tag_lookup_engine.sv */
/*
 * Tag lookup engine.
 * Reads the two hash buckets of a key, picks the matching one
 * (table 0 first), streams its values and reports hit or miss.
 */
module tag_lookup_engine #(
	parameter int NUM_PU = 4,
	localparam int PID_W = (NUM_PU > 1) ? $clog2(NUM_PU) : 1
) (
	input  logic clk,
	input  logic rst_n,

	input  logic key_valid,
	input  logic [tag_req_pkg::TAG_W-1:0] key_tag,
	input  logic [PID_W-1:0] key_pid,

	input  logic ht0_ack,
	input  logic [tag_req_pkg::REG_W-1:0] ht0_rdata,
	input  logic ht1_ack,
	input  logic [tag_req_pkg::REG_W-1:0] ht1_rdata,
	input  logic val_ack,
	input  logic [tag_req_pkg::RESULT_W-1:0] val_rdata,

	output logic engine_idle,
	output logic ht0_rd,
	output logic [tag_req_pkg::HT_DEPTH_W-1:0] ht0_raddr,
	output logic ht1_rd,
	output logic [tag_req_pkg::HT_DEPTH_W-1:0] ht1_raddr,
	output logic val_rd,
	output logic [tag_req_pkg::VAL_DEPTH_W-1:0] val_raddr,

	output logic lookup_valid,
	output logic [tag_req_pkg::RESULT_W-1:0] lookup_result,
	output logic [tag_req_pkg::CNT_W-1:0] lookup_result_num,
	output logic [PID_W-1:0] lookup_result_pid,
	output logic status_valid,
	output logic [tag_req_pkg::STATUS_W-1:0] status,
	output logic [PID_W-1:0] status_pid
);
	import tag_req_pkg::*;

	localparam logic [2:0] S_IDLE    = 3'd0;
	localparam logic [2:0] S_BUCKET  = 3'd1;	// Bucket reads in flight
	localparam logic [2:0] S_COMPARE = 3'd2;
	localparam logic [2:0] S_STREAM  = 3'd3;
	localparam logic [2:0] S_STATUS  = 3'd4;

	logic [2:0] state;
	logic [TAG_W-1:0] tag_q;
	logic [PID_W-1:0] pid_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] issue_cnt;	// Value reads issued
	logic [CNT_W-1:0] res_num;	// Value acks seen
	logic hit0, hit1;
	logic [REG_W-1:0] sel_bkt;
	logic more_reads;

	//--------------------------------------------------
	// Bucket match
	//--------------------------------------------------
	// A count of zero never matches
	assign hit0 = ht0_ack & ht0_rdata[BKT_VALID_BIT] &
		(ht0_rdata[BKT_TAG_HI:BKT_TAG_LO] == tag_q) &
		(ht0_rdata[BKT_CNT_HI:BKT_CNT_LO] != '0);
	assign hit1 = ht1_ack & ht1_rdata[BKT_VALID_BIT] &
		(ht1_rdata[BKT_TAG_HI:BKT_TAG_LO] == tag_q) &
		(ht1_rdata[BKT_CNT_HI:BKT_CNT_LO] != '0);
	assign sel_bkt = hit0 ? ht0_rdata : ht1_rdata;	// Table 0 wins

	assign more_reads = (issue_cnt != cnt_q);

	//--------------------------------------------------
	// Control FSM
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= S_IDLE;
			ht0_rd       <= 1'b0;
			ht1_rd       <= 1'b0;
			val_rd       <= 1'b0;
			status_valid <= 1'b0;
			issue_cnt    <= '0;
			res_num      <= '0;
		end else begin
			ht0_rd       <= 1'b0;
			ht1_rd       <= 1'b0;
			status_valid <= 1'b0;
			case (state)
			S_IDLE: begin
				if (key_valid) begin
					ht0_rd <= 1'b1;
					ht1_rd <= 1'b1;
					state  <= S_BUCKET;
				end
			end
			S_BUCKET: state <= S_COMPARE;
			S_COMPARE: begin
				res_num <= '0;
				if (hit0 | hit1) begin
					val_rd    <= 1'b1;
					issue_cnt <= CNT_W'(1);
					state     <= S_STREAM;
				end else begin
					status_valid <= 1'b1;	// Miss
					state        <= S_STATUS;
				end
			end
			S_STREAM: begin
				val_rd <= more_reads;
				if (more_reads)
					issue_cnt <= issue_cnt + 1'b1;
				if (val_ack) begin
					res_num <= res_num + 1'b1;
					if ((res_num + 3'd1) == cnt_q) begin	// Last value
						status_valid <= 1'b1;
						state        <= S_STATUS;
					end
				end
			end
			S_STATUS: state <= S_IDLE;
			default:  state <= S_IDLE;
			endcase
		end
	end

	//--------------------------------------------------
	// Key, addresses and bucket fields
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == S_IDLE && key_valid) begin
			tag_q     <= key_tag;
			pid_q     <= key_pid;
			ht0_raddr <= hash0(key_tag);
			ht1_raddr <= hash1(key_tag);
		end
		if (state == S_COMPARE) begin
			cnt_q     <= sel_bkt[BKT_CNT_HI:BKT_CNT_LO];
			val_raddr <= sel_bkt[BKT_BASE_HI:BKT_BASE_LO];
			status    <= (hit0 | hit1) ? STATUS_HIT : STATUS_MISS;
		end
		if (state == S_STREAM && more_reads)
			val_raddr <= val_raddr + 1'b1;	// Wraps modulo 32
	end

	assign engine_idle       = (state == S_IDLE);
	assign lookup_valid      = val_ack;
	assign lookup_result     = val_rdata;
	assign lookup_result_num = res_num;
	assign lookup_result_pid = pid_q;
	assign status_pid        = pid_q;

endmodule

/* design/tag_req_arbiter.sv */
/*
 * Lookup request arbiter.
 * Holds one pending tag per PU and hands them to the lookup
 * engine round-robin while it is idle. Acks the PU a cycle later.
 */
module tag_req_arbiter #(
	parameter int NUM_PU = 4,
	localparam int PID_W = (NUM_PU > 1) ? $clog2(NUM_PU) : 1
) (
	input  logic clk,
	input  logic rst_n,

	input  logic [NUM_PU-1:0] io_req,
	input  logic [NUM_PU-1:0] io_wr,
	input  logic [tag_req_pkg::IO_ADDR_W-1:0] io_addr [NUM_PU],
	input  logic [tag_req_pkg::REG_W-1:0] io_wdata [NUM_PU],
	input  logic engine_idle,

	output logic [NUM_PU-1:0] io_ack,
	output logic key_valid,
	output logic [tag_req_pkg::TAG_W-1:0] key_tag,
	output logic [PID_W-1:0] key_pid
);
	import tag_req_pkg::*;

	logic [NUM_PU-1:0] pend;
	logic [NUM_PU-1:0] accept;
	logic [NUM_PU-1:0] gnt_vec;
	logic [TAG_W-1:0] tag_q [NUM_PU];
	logic [PID_W-1:0] last_q;	// Last PU granted
	logic [PID_W-1:0] gnt_idx;

	always_comb begin
		for (int i = 0; i < NUM_PU; i++) begin
			accept[i] = io_req[i] & io_wr[i] & (io_addr[i] == TAG_LOOKUP_ADDR) & ~pend[i];
		end
	end

	// Nearest pending PU after the last grant wins
	always_comb begin : rr_search
		int cand;
		gnt_idx = last_q;
		for (int k = NUM_PU; k >= 1; k--) begin
			cand = int'(last_q) + k;
			if (cand >= NUM_PU)
				cand = cand - NUM_PU;
			if (pend[cand])
				gnt_idx = PID_W'(cand);
		end
	end

	assign key_valid = engine_idle & (|pend);
	assign key_tag   = tag_q[gnt_idx];
	assign key_pid   = gnt_idx;

	always_comb begin
		for (int i = 0; i < NUM_PU; i++)
			gnt_vec[i] = key_valid & (int'(gnt_idx) == i);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pend   <= '0;
			io_ack <= '0;
			last_q <= PID_W'(NUM_PU - 1);	// First search starts at PU 0
		end else begin
			pend   <= (pend & ~gnt_vec) | accept;
			io_ack <= gnt_vec;
			if (key_valid)
				last_q <= gnt_idx;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_PU; i++) begin
			if (accept[i])
				tag_q[i] <= io_wdata[i][TAG_W-1:0];
		end
	end

endmodule

/* design/tag_table_mem.sv */
/*
 * Tag hash and value tables.
 * Two 16 x 32 bucket arrays and a 32 x 16 value array, written and
 * read over the register port, with a separate engine read port.
 */
module tag_table_mem (
	input  logic clk,
	input  logic rst_n,

	input  logic [7:0] reg_addr,
	input  logic [tag_req_pkg::REG_W-1:0] reg_din,
	input  logic reg_rd,
	input  logic reg_wr,
	input  logic reg_sel_hash,
	input  logic reg_sel_value,

	input  logic ht0_rd,
	input  logic [tag_req_pkg::HT_DEPTH_W-1:0] ht0_raddr,
	input  logic ht1_rd,
	input  logic [tag_req_pkg::HT_DEPTH_W-1:0] ht1_raddr,
	input  logic val_rd,
	input  logic [tag_req_pkg::VAL_DEPTH_W-1:0] val_raddr,

	output logic hash_mem_ack,
	output logic [tag_req_pkg::REG_W-1:0] hash_mem_rdata,
	output logic value_mem_ack,
	output logic [tag_req_pkg::REG_W-1:0] value_mem_rdata,

	output logic ht0_ack,
	output logic [tag_req_pkg::REG_W-1:0] ht0_rdata,
	output logic ht1_ack,
	output logic [tag_req_pkg::REG_W-1:0] ht1_rdata,
	output logic val_ack,
	output logic [tag_req_pkg::RESULT_W-1:0] val_rdata
);
	import tag_req_pkg::*;

	localparam int HT_DEPTH  = 1 << HT_DEPTH_W;
	localparam int VAL_DEPTH = 1 << VAL_DEPTH_W;

	logic [REG_W-1:0] ht0_mem [HT_DEPTH];
	logic [REG_W-1:0] ht1_mem [HT_DEPTH];
	logic [RESULT_W-1:0] val_mem [VAL_DEPTH];

	logic [HT_DEPTH_W-1:0] reg_bkt;
	logic [VAL_DEPTH_W-1:0] reg_vidx;
	logic reg_ht1;	// Bit 4 selects table 1

	assign reg_ht1  = reg_addr[4];
	assign reg_bkt  = reg_addr[HT_DEPTH_W-1:0];
	assign reg_vidx = reg_addr[VAL_DEPTH_W-1:0];

	//--------------------------------------------------
	// Table contents
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < HT_DEPTH; i++) begin
				ht0_mem[i] <= '0;	// All buckets invalid
				ht1_mem[i] <= '0;
			end
			for (int i = 0; i < VAL_DEPTH; i++)
				val_mem[i] <= '0;
		end else begin
			if (reg_wr && reg_sel_hash) begin
				if (reg_ht1)
					ht1_mem[reg_bkt] <= reg_din;
				else
					ht0_mem[reg_bkt] <= reg_din;
			end
			if (reg_wr && reg_sel_value)
				val_mem[reg_vidx] <= reg_din[RESULT_W-1:0];
		end
	end

	//--------------------------------------------------
	// Register port acks and read data
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hash_mem_ack  <= 1'b0;
			value_mem_ack <= 1'b0;
		end else begin
			hash_mem_ack  <= reg_sel_hash & (reg_rd | reg_wr);
			value_mem_ack <= reg_sel_value & (reg_rd | reg_wr);
		end
	end

	always_ff @(posedge clk) begin
		if (reg_rd && reg_sel_hash)
			hash_mem_rdata <= reg_ht1 ? ht1_mem[reg_bkt] : ht0_mem[reg_bkt];
		if (reg_rd && reg_sel_value)
			value_mem_rdata <= {{(REG_W-RESULT_W){1'b0}}, val_mem[reg_vidx]};
	end

	//--------------------------------------------------
	// Engine read port
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ht0_ack <= 1'b0;
			ht1_ack <= 1'b0;
			val_ack <= 1'b0;
		end else begin
			ht0_ack <= ht0_rd;
			ht1_ack <= ht1_rd;
			val_ack <= val_rd;
		end
	end

	// Old contents on a same-cycle register write
	always_ff @(posedge clk) begin
		if (ht0_rd)
			ht0_rdata <= ht0_mem[ht0_raddr];
		if (ht1_rd)
			ht1_rdata <= ht1_mem[ht1_raddr];
		if (val_rd)
			val_rdata <= val_mem[val_raddr];
	end

endmodule

/* design/tag_req_pkg.sv */
/*
 * Tag lookup subsystem shared definitions.
 * Widths, the lookup I/O address, status codes,
 * bucket word fields and the two bucket hash functions.
 */
package tag_req_pkg;

	//--------------------------------------------------
	// Widths
	//--------------------------------------------------
	localparam int TAG_W       = 16;	// Lookup tag
	localparam int REG_W       = 32;	// Register port and I/O write data
	localparam int IO_ADDR_W   = 12;
	localparam int HT_DEPTH_W  = 4;		// 16 buckets per table
	localparam int VAL_DEPTH_W = 5;		// 32 value entries
	localparam int RESULT_W    = 16;
	localparam int CNT_W       = 3;		// Values per bucket, 0 to 7
	localparam int STATUS_W    = 4;

	localparam logic [IO_ADDR_W-1:0] TAG_LOOKUP_ADDR = 12'h0A0;

	//--------------------------------------------------
	// Bucket word fields
	//--------------------------------------------------
	localparam int BKT_VALID_BIT = 31;
	localparam int BKT_CNT_HI    = 23;
	localparam int BKT_CNT_LO    = 21;
	localparam int BKT_BASE_HI   = 20;
	localparam int BKT_BASE_LO   = 16;
	localparam int BKT_TAG_HI    = 15;
	localparam int BKT_TAG_LO    = 0;

	localparam logic [STATUS_W-1:0] STATUS_HIT  = 4'd1;
	localparam logic [STATUS_W-1:0] STATUS_MISS = 4'd2;

	// Bucket index into table 0
	function automatic logic [HT_DEPTH_W-1:0] hash0(input logic [TAG_W-1:0] tag);
		return tag[3:0] ^ tag[11:8];
	endfunction

	// Bucket index into table 1
	function automatic logic [HT_DEPTH_W-1:0] hash1(input logic [TAG_W-1:0] tag);
		return tag[7:4] ^ tag[15:12];
	endfunction

endpackage
